/* dv/apb_uart_stimulus.txt */
// Columns, all hex: op addr wdata strb b0 b1 b2 b3 hold exp_prdata exp_err
// op 1 is a write, 0 a read. b0..b3 are the UART receive bytes, b0 first;
// hold 1 delivers only b0 and b1. exp_prdata and exp_err are prdata and pslverr.

// Configuration and control writes
1 008 000000A5 F 00 00 00 00 0 00000000 0
1 008 12345678 1 00 00 00 00 0 00000000 0
1 00C 00000003 F 00 00 00 00 0 00000000 0
1 00C 00000002 F 00 00 00 00 0 00000000 0
1 00C 0000FF81 3 00 00 00 00 0 00000000 0

// Strobed transmit writes
1 000 44332211 F 00 00 00 00 0 00000000 0
1 000 DDCCBBAA 5 00 00 00 00 0 00000000 0
1 000 DDCCBBAA 0 00 00 00 00 0 00000000 0
1 000 87654321 8 00 00 00 00 0 00000000 0
1 000 0F0E0D0C A 00 00 00 00 0 00000000 0
1 000 00C0FFEE 6 00 00 00 00 0 00000000 0
1 000 5566AA99 1 00 00 00 00 0 00000000 0

// Receive data reads
0 000 00000000 0 5A 00 00 00 0 0000005A 0
0 000 00000000 0 00 00 00 00 0 00000000 0
0 000 00000000 0 C3 00 00 00 0 000000C3 0

// Receive word reads
0 004 00000000 0 11 22 33 44 0 44332211 0
0 004 00000000 0 DE AD BE EF 0 EFBEADDE 0
0 004 00000000 0 00 FF 00 FF 0 FF00FF00 0

// Receive word timeouts
0 004 00000000 0 01 02 03 04 1 00000201 1
0 004 00000000 0 AB CD EF 12 1 0000CDAB 1

// Slave errors
0 010 00000000 0 00 00 00 00 0 00000000 1
1 010 000000FF F 00 00 00 00 0 00000000 1
1 004 12345678 F 00 00 00 00 0 00000000 1
0 008 00000000 0 00 00 00 00 0 00000000 1
0 00C 00000000 0 00 00 00 00 0 00000000 1
1 014 00000055 F 00 00 00 00 0 00000000 1
0 1FFC 00000000 0 00 00 00 00 0 00000000 1
1 002 00000011 F 00 00 00 00 0 00000000 1

// Mixed traffic
0 000 00000000 0 77 00 00 00 0 00000077 0
1 00C 00000001 F 00 00 00 00 0 00000000 0
0 004 00000000 0 10 20 30 40 0 40302010 0

/* all.f */
rtl/uart_apb_pkg.sv
rtl/apb_phase_ctrl.sv
rtl/tx_byte_sequencer.sv
rtl/rx_word_assembler.sv
rtl/apb_uart_bridge.sv
dv/apb_uart_bridge_assertions.sv
dv/tb_apb_uart_bridge.sv

/* Bender.yml */
package:
  name: apb_uart_bridge

sources:
  # RTL in compile order
  - rtl/uart_apb_pkg.sv
  - rtl/apb_phase_ctrl.sv
  - rtl/tx_byte_sequencer.sv
  - rtl/rx_word_assembler.sv
  - rtl/apb_uart_bridge.sv

  # Verification sources
  - target: test
    files:
      - dv/apb_uart_bridge_assertions.sv
      - dv/tb_apb_uart_bridge.sv

/* dv/tb_apb_uart_bridge.sv */
module tb_apb_uart_bridge;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 40;   // Short RX timeout for simulation
    localparam int RESET_NS       = 40;   // 4 cycles of 10 ns
    localparam int NS_PER_LINE    = 600;  // Watchdog budget per vector

    logic                            pclk;
    logic                            presetn;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [uart_apb_pkg::ADDR_W-1:0] paddr;
    logic [uart_apb_pkg::DATA_W-1:0] pwdata;
    logic [uart_apb_pkg::STRB_W-1:0] pstrb;
    logic                            tx_done;   // UART model outputs
    logic                            rx_done;
    logic [uart_apb_pkg::BYTE_W-1:0] rx_data;
    uart_apb_pkg::uart_stat_t        uart_stat;
    logic                            pready;
    logic                            pslverr;
    logic [uart_apb_pkg::DATA_W-1:0] prdata;
    uart_apb_pkg::reg_wr_t           reg_wr;

    logic                            v_op[$];       // 1 write, 0 read
    logic [uart_apb_pkg::ADDR_W-1:0] v_addr[$];
    logic [31:0]                     v_wdata[$];
    logic [3:0]                      v_strb[$];
    logic [31:0]                     v_rx[$];       // b3..b0, b0 sent first
    logic                            v_hold[$];     // Only two bytes delivered
    logic [31:0]                     v_rdata[$];
    logic                            v_err[$];
    uart_apb_pkg::reg_wr_t           wr_log[$];     // Seen on reg_wr
    uart_apb_pkg::reg_wr_t           exp_wr[$];     // Predicted from the vector
    int                              seed = 32'h8c853e19;
    int                              n_vec = 0;
    bit                              tx_busy = 1'b0;  // tx_done still pending

    assign uart_stat = '{rx_data: rx_data, tx_done: tx_done, rx_done: rx_done};

    apb_uart_bridge #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) UUT (
        .pclk(pclk), .presetn(presetn), .psel(psel), .penable(penable),
        .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
        .uart_stat(uart_stat), .pready(pready), .pslverr(pslverr),
        .prdata(prdata), .reg_wr(reg_wr)
    );

    initial
    begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;  // 100 MHz
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic load_vectors();
        int                fd;
        int                cnt;
        logic [8*160-1:0]  line;
        logic [31:0]       f[11];  // op addr wdata strb b0 b1 b2 b3 hold rdata err
        fd = $fopen("dv/apb_uart_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file dv/apb_uart_stimulus.txt");
            $display("Simulation finished: FAIL");
            $fatal(1, "No stimulus");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = '0;
                cnt  = $fgets(line, fd);
                cnt  = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                               f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                if (cnt == 11)  // Comment and blank lines skipped
                begin
                    v_op.push_back(f[0][0]);
                    v_addr.push_back(f[1][uart_apb_pkg::ADDR_W-1:0]);
                    v_wdata.push_back(f[2]);
                    v_strb.push_back(f[3][3:0]);
                    v_rx.push_back({f[7][7:0], f[6][7:0], f[5][7:0], f[4][7:0]});
                    v_hold.push_back(f[8][0]);
                    v_rdata.push_back(f[9]);
                    v_err.push_back(f[10][0]);
                end
            end
            $fclose(fd);
            n_vec = v_op.size();
        end
    endtask

    // ==============================
    // UART model
    // ==============================
    initial
    begin : tx_responder
        int delay;
        forever
        begin
            @(negedge pclk);
            if (reg_wr.valid)
            begin
                wr_log.push_back(reg_wr);
                if (reg_wr.start_tx)
                begin
                    tx_busy = 1'b1;
                    delay   = 1 + ($unsigned($random(seed)) % 6);  // 1 to 6 cycles
                    repeat (delay) @(posedge pclk);
                    tx_done <= 1'b1;
                    @(posedge pclk);
                    tx_done <= 1'b0;
                    tx_busy = 1'b0;
                end
            end
        end
    end

    task automatic feed_rx(input logic [31:0] bytes, input logic hold);
        int gap;
        int n;
        n = hold ? 2 : 4;  // Withheld bytes force the timeout
        for (int k = 0; k < n; k++)
        begin
            gap = 1 + ($unsigned($random(seed)) % 10);
            repeat (gap) @(posedge pclk);
            rx_data <= bytes[k*8 +: 8];
            rx_done <= 1'b1;
            @(posedge pclk);
            rx_done <= 1'b0;
        end
    endtask

    task automatic wait_response(output logic [31:0] rdata, output logic err);
        do
        begin
            @(negedge pclk);  // Sample away from the driving edge
        end
        while (!pready);
        rdata = prdata;
        err   = pslverr;
    endtask

    // Register-side writes that the vector should cause
    task automatic expect_writes(input int i);
        if (v_op[i] && !v_err[i])
        begin
            if (v_addr[i] == uart_apb_pkg::ADDR_CFG)
                exp_wr.push_back('{1'b1, 5'h08, v_wdata[i][7:0], 1'b0});
            else if (v_addr[i] == uart_apb_pkg::ADDR_CTRL)
                exp_wr.push_back('{1'b1, 5'h0C, v_wdata[i][7:0], v_wdata[i][0]});
            else
                for (int lane = 0; lane < 4; lane++)  // Lowest lane first
                    if (v_strb[i][lane])
                        exp_wr.push_back('{1'b1, 5'h00, v_wdata[i][lane*8 +: 8], 1'b1});
        end
    endtask

    task automatic compare_writes();
        check_value("reg_wr count", wr_log.size(), exp_wr.size());
        foreach (exp_wr[k])
        begin
            check_value("reg_wr.addr", wr_log[k].addr, exp_wr[k].addr);
            check_value("reg_wr.data", wr_log[k].data, exp_wr[k].data);
            check_value("reg_wr.start_tx", wr_log[k].start_tx, exp_wr[k].start_tx);
        end
        wr_log.delete();
        exp_wr.delete();
    endtask

    // ==============================
    // Watchdog
    // ==============================
    initial
    begin : watchdog
        wait (n_vec > 0);
        #(n_vec * NS_PER_LINE + RESET_NS);
        $display("Timeout: the transactions did not complete in %0d ns",
                 n_vec * NS_PER_LINE + RESET_NS);
        $display("Simulation finished: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin : main
        logic [31:0] rdata;
        logic        err;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        pstrb   = '0;
        tx_done = 1'b0;
        rx_done = 1'b0;
        rx_data = '0;
        presetn = 1'b0;
        load_vectors();
        check_value("vector count nonzero", (n_vec > 0), 1'b1);
        repeat (4) @(posedge pclk);
        presetn <= 1'b1;
        @(negedge pclk);
        check_value("pready", pready, 1'b0);  // Quiet after reset
        check_value("pslverr", pslverr, 1'b0);
        check_value("prdata", prdata, 32'h0);
        check_value("reg_wr.valid", reg_wr.valid, 1'b0);
        for (int i = 0; i < n_vec; i++)
        begin
            @(posedge pclk);
            psel    <= 1'b1;  // Setup phase
            penable <= 1'b0;
            pwrite  <= v_op[i];
            paddr   <= v_addr[i];
            pwdata  <= v_wdata[i];
            pstrb   <= v_strb[i];
            if (!v_op[i] && v_addr[i] == uart_apb_pkg::ADDR_TX_DATA)
                rx_data <= v_rx[i][7:0];  // Current received byte
            @(posedge pclk);
            penable <= 1'b1;  // Access phase
            if (!v_op[i] && v_addr[i] == uart_apb_pkg::ADDR_RX_WORD)
            begin
                fork
                    feed_rx(v_rx[i], v_hold[i]);
                    wait_response(rdata, err);
                join
            end
            else
                wait_response(rdata, err);
            @(posedge pclk);
            psel    <= 1'b0;
            penable <= 1'b0;
            wait (!tx_busy);  // Let a control kick finish
            check_value("prdata", rdata, v_rdata[i]);
            check_value("pslverr", err, v_err[i]);
            expect_writes(i);
            compare_writes();
        end
        repeat (2) @(posedge pclk);
        if (UUT.u_phase.u_assert.violations == 0)
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
        else
        begin
            $display("Assertion failures: %0d", UUT.u_phase.u_assert.violations);
            $display("Simulation finished: FAIL");
            $fatal(1, "Assertions failed");
        end
    end

endmodule

/* dv/apb_uart_bridge_assertions.sv */
module apb_uart_bridge_assertions (
    input logic                  pclk,
    input logic                  presetn,
    input uart_apb_pkg::apb_req_t req,
    input logic                  pready,
    input logic                  pslverr,
    input uart_apb_pkg::reg_wr_t reg_wr
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned violations = 0;  // Read by the testbench at the end

    // ==============================
    // APB response
    // ==============================
    a_pready_pulse: assert property (@(posedge pclk) disable iff (!presetn)
        pready |=> !pready)  // Single-cycle pready
    else
    begin
        $error("pready stayed high for more than one cycle");
        violations++;
    end

    a_err_with_ready: assert property (@(posedge pclk) disable iff (!presetn)
        pslverr |-> pready)
    else
    begin
        $error("pslverr high without pready");
        violations++;
    end

    // Register-side pulses only while a transfer is open
    a_wr_in_access: assert property (@(posedge pclk) disable iff (!presetn)
        reg_wr.valid |-> (req.sel && req.enable))
    else
    begin
        $error("reg_wr.valid outside an APB access phase");
        violations++;
    end

endmodule

bind apb_phase_ctrl apb_uart_bridge_assertions u_assert (
    .pclk(pclk), .presetn(presetn), .req(req), .pready(pready),
    .pslverr(pslverr), .reg_wr(reg_wr)
);

/* rtl/apb_uart_bridge.sv */
module apb_uart_bridge #(
    parameter int TIMEOUT_CYCLES = 50_000_000  // 1 s at 50 MHz
) (
    input  logic                            pclk,
    input  logic                            presetn,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [uart_apb_pkg::ADDR_W-1:0] paddr,
    input  logic [uart_apb_pkg::DATA_W-1:0] pwdata,
    input  logic [uart_apb_pkg::STRB_W-1:0] pstrb,
    input  uart_apb_pkg::uart_stat_t        uart_stat,  // From register block
    output logic                            pready,
    output logic                            pslverr,
    output logic [uart_apb_pkg::DATA_W-1:0] prdata,
    output uart_apb_pkg::reg_wr_t           reg_wr      // To register block
);

    uart_apb_pkg::apb_req_t          req;
    uart_apb_pkg::reg_wr_t           seq_wr;     // TX byte writes
    logic                            tx_start;
    logic                            rx_start;
    logic                            tx_done_pulse;
    logic                            rx_done_pulse;
    logic                            rx_err;
    logic [uart_apb_pkg::DATA_W-1:0] rx_word;

    assign req = '{sel: psel, enable: penable, write: pwrite,
                   addr: paddr, wdata: pwdata, strb: pstrb};

    // ==============================
    // APB front end
    // ==============================
    apb_phase_ctrl u_phase (
        .pclk(pclk), .presetn(presetn), .req(req), .rx_data(uart_stat.rx_data),
        .tx_done_pulse(tx_done_pulse), .rx_done_pulse(rx_done_pulse),
        .rx_err(rx_err), .rx_word(rx_word), .seq_wr(seq_wr),
        .pready(pready), .pslverr(pslverr), .prdata(prdata),
        .tx_start(tx_start), .rx_start(rx_start), .reg_wr(reg_wr)
    );

    // ==============================
    // Engines
    // ==============================
    tx_byte_sequencer u_tx_seq (
        .pclk(pclk), .presetn(presetn), .start(tx_start),
        .wdata(req.wdata), .strb(req.strb), .tx_done(uart_stat.tx_done),
        .wr(seq_wr), .done(tx_done_pulse)
    );

    rx_word_assembler #(
        .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
    ) u_rx_asm (
        .pclk(pclk), .presetn(presetn), .start(rx_start),
        .rx_done(uart_stat.rx_done), .rx_data(uart_stat.rx_data),
        .done(rx_done_pulse), .err(rx_err), .word(rx_word)
    );

endmodule

/* rtl/rx_word_assembler.sv */
module rx_word_assembler #(
    parameter int TIMEOUT_CYCLES = 50_000_000  // Idle cycles before giving up
) (
    input  logic                            pclk,
    input  logic                            presetn,
    input  logic                            start,    // First access cycle of word read
    input  logic                            rx_done,  // UART received a byte
    input  logic [uart_apb_pkg::BYTE_W-1:0] rx_data,
    output logic                            done,
    output logic                            err,      // Timed out
    output logic [uart_apb_pkg::DATA_W-1:0] word
);

    localparam int TMR_W = $clog2(TIMEOUT_CYCLES + 1);
    localparam int CNT_W = $clog2(uart_apb_pkg::STRB_W);

    logic                            active_q;   // Collecting
    logic [CNT_W-1:0]                cnt_q;      // Next lane to fill
    logic [TMR_W-1:0]                tmr_q;      // Cycles since start or last byte
    logic [uart_apb_pkg::DATA_W-1:0] word_q;
    logic [uart_apb_pkg::DATA_W-1:0] word_next;
    logic                            take;
    logic                            last;
    logic                            expired;

    // ==============================
    // Completion
    // ==============================
    assign take    = active_q && rx_done;
    assign last    = take && (cnt_q == CNT_W'(uart_apb_pkg::STRB_W - 1));  // Fourth byte
    assign expired = active_q && !rx_done && (tmr_q == TMR_W'(TIMEOUT_CYCLES - 1));
    assign done    = last || expired;
    assign err     = expired;

    // Merge the arriving byte so the fourth shows up with done
    always_comb
    begin
        word_next = word_q;
        if (take)
            word_next[cnt_q*uart_apb_pkg::BYTE_W +: uart_apb_pkg::BYTE_W] = rx_data;
    end

    assign word = word_next;  // Missing lanes stay zero

    always_ff @(posedge pclk)
    begin
        if (!presetn)
        begin
            active_q <= 1'b0;
            cnt_q    <= '0;
            tmr_q    <= '0;
        end
        else if (start)
        begin
            active_q <= 1'b1;
            cnt_q    <= '0;
            tmr_q    <= '0;
        end
        else if (done)
            active_q <= 1'b0;
        else if (take)
        begin
            cnt_q <= cnt_q + 1'b1;
            tmr_q <= '0;       // Restart timeout per byte
        end
        else if (active_q)
            tmr_q <= tmr_q + 1'b1;
    end

    always_ff @(posedge pclk)
    begin
        if (start)
            word_q <= '0;
        else if (take)
            word_q <= word_next;
    end

endmodule

/* rtl/tx_byte_sequencer.sv */
module tx_byte_sequencer (
    input  logic                            pclk,
    input  logic                            presetn,
    input  logic                            start,    // First access cycle of TX write
    input  logic [uart_apb_pkg::DATA_W-1:0] wdata,
    input  logic [uart_apb_pkg::STRB_W-1:0] strb,
    input  logic                            tx_done,  // UART finished a byte
    output uart_apb_pkg::reg_wr_t           wr,
    output logic                            done
);

    localparam int LANE_W = $clog2(uart_apb_pkg::STRB_W);

    logic                            busy_q;      // Byte in flight
    logic [uart_apb_pkg::DATA_W-1:0] data_q;      // Latched write data
    logic [uart_apb_pkg::STRB_W-1:0] rem_q;       // Lanes still to send
    logic                            wr_valid_q;
    logic [uart_apb_pkg::BYTE_W-1:0] wr_data_q;
    logic                            advance;     // Pick next lane this cycle
    logic [uart_apb_pkg::STRB_W-1:0] lanes;
    logic [uart_apb_pkg::DATA_W-1:0] src_data;
    logic [LANE_W-1:0]               lane;        // Lowest enabled lane
    logic                            found;

    assign advance  = start || (busy_q && tx_done);
    assign lanes    = start ? strb : rem_q;    // Fresh strobe or leftovers
    assign src_data = start ? wdata : data_q;

    // Lowest set lane wins, disabled lanes skipped
    always_comb
    begin
        lane  = '0;
        found = 1'b0;
        for (int i = uart_apb_pkg::STRB_W - 1; i >= 0; i--)
        begin
            if (lanes[i])
            begin
                lane  = LANE_W'(i);
                found = 1'b1;
            end
        end
    end

    assign done = advance && !found;  // Zero strobe or last byte sent

    always_ff @(posedge pclk)
    begin
        if (!presetn)
        begin
            busy_q     <= 1'b0;
            wr_valid_q <= 1'b0;
        end
        else
        begin
            wr_valid_q <= advance && found;  // One pulse per byte
            if (advance)
                busy_q <= found;
        end
    end

    always_ff @(posedge pclk)
    begin
        if (start)
            data_q <= wdata;
        if (advance)
        begin
            rem_q     <= lanes & (lanes - 1'b1);  // Drop the lane just sent
            wr_data_q <= src_data[lane*uart_apb_pkg::BYTE_W +: uart_apb_pkg::BYTE_W];
        end
    end

    assign wr = '{valid:    wr_valid_q,
                  addr:     uart_apb_pkg::ADDR_TX_DATA[uart_apb_pkg::REG_ADDR_W-1:0],
                  data:     wr_data_q,
                  start_tx: wr_valid_q};  // Every TX byte starts the UART

endmodule

/* rtl/apb_phase_ctrl.sv */
module apb_phase_ctrl (
    input  logic                            pclk,
    input  logic                            presetn,
    input  uart_apb_pkg::apb_req_t          req,
    input  logic [uart_apb_pkg::BYTE_W-1:0] rx_data,
    input  logic                            tx_done_pulse,  // From TX sequencer
    input  logic                            rx_done_pulse,  // From RX assembler
    input  logic                            rx_err,         // RX timeout
    input  logic [uart_apb_pkg::DATA_W-1:0] rx_word,
    input  uart_apb_pkg::reg_wr_t           seq_wr,         // TX byte writes
    output logic                            pready,
    output logic                            pslverr,
    output logic [uart_apb_pkg::DATA_W-1:0] prdata,
    output logic                            tx_start,
    output logic                            rx_start,
    output uart_apb_pkg::reg_wr_t           reg_wr
);

    typedef enum logic [1:0] {
        ST_IDLE,  // Waiting for an access phase
        ST_BUSY,  // Engine running
        ST_RESP   // pready high this cycle
    } state_t;

    state_t                state_q;
    logic                  access;
    logic                  first;     // First access cycle in idle
    logic                  hit_tx;
    logic                  hit_rxw;
    logic                  hit_cfg;
    logic                  hit_ctrl;
    logic                  hit_rxb;
    logic                  bad;       // Slave error response
    logic                  simple;    // Answered without an engine
    logic                  eng_done;
    uart_apb_pkg::reg_wr_t ctl_wr_q;  // CFG / CTRL byte write

    // ==============================
    // Address decode
    // ==============================
    assign access   = req.sel && req.enable;
    assign first    = access && (state_q == ST_IDLE);
    assign hit_tx   = req.write && (req.addr == uart_apb_pkg::ADDR_TX_DATA);
    assign hit_rxw  = !req.write && (req.addr == uart_apb_pkg::ADDR_RX_WORD);
    assign hit_cfg  = req.write && (req.addr == uart_apb_pkg::ADDR_CFG);
    assign hit_ctrl = req.write && (req.addr == uart_apb_pkg::ADDR_CTRL);
    assign hit_rxb  = !req.write && (req.addr == uart_apb_pkg::ADDR_TX_DATA);
    assign bad      = !(hit_cfg || hit_ctrl || hit_rxb);  // Status and unmapped land here

    assign tx_start = first && hit_tx;   // Zero strobe finishes same cycle
    assign rx_start = first && hit_rxw;
    assign simple   = first && !hit_tx && !hit_rxw;
    assign eng_done = tx_done_pulse || rx_done_pulse;

    assign reg_wr = seq_wr.valid ? seq_wr : ctl_wr_q;  // Sources never overlap

    // ==============================
    // Response FSM
    // ==============================
    always_ff @(posedge pclk)
    begin
        if (!presetn)
        begin
            state_q  <= ST_IDLE;
            pready   <= 1'b0;
            pslverr  <= 1'b0;
            prdata   <= '0;
            ctl_wr_q <= '0;
        end
        else
        begin
            ctl_wr_q.valid    <= 1'b0;  // Single-cycle pulse
            ctl_wr_q.start_tx <= 1'b0;
            if (state_q == ST_RESP)
            begin
                pready  <= 1'b0;         // Back to idle, wait for next setup
                pslverr <= 1'b0;
                state_q <= ST_IDLE;
            end
            else if (eng_done)
            begin
                pready  <= 1'b1;
                pslverr <= rx_done_pulse && rx_err;                 // Only RX can time out
                prdata  <= rx_done_pulse ? rx_word : '0;            // Partial word on timeout
                state_q <= ST_RESP;
            end
            else if (simple)
            begin
                pready  <= 1'b1;  // One wait state
                pslverr <= bad;
                prdata  <= hit_rxb
                         ? {{(uart_apb_pkg::DATA_W - uart_apb_pkg::BYTE_W){1'b0}}, rx_data}
                         : '0;
                ctl_wr_q.valid    <= hit_cfg || hit_ctrl;
                ctl_wr_q.addr     <= req.addr[uart_apb_pkg::REG_ADDR_W-1:0];
                ctl_wr_q.data     <= req.wdata[uart_apb_pkg::BYTE_W-1:0];  // Low byte only
                ctl_wr_q.start_tx <= hit_ctrl && req.wdata[0];
                state_q <= ST_RESP;
            end
            else if (tx_start || rx_start)
            begin
                state_q <= ST_BUSY;  // Wait for engine done
            end
        end
    end

endmodule

/* rtl/uart_apb_pkg.sv */
package uart_apb_pkg;

    // ==============================
    // Bus widths
    // ==============================
    localparam int ADDR_W     = 13;          // APB address
    localparam int DATA_W     = 32;          // APB data
    localparam int STRB_W     = DATA_W / 8;  // One strobe per byte lane
    localparam int BYTE_W     = 8;
    localparam int REG_ADDR_W = 5;           // Register block side

    // ==============================
    // Register map
    // ==============================
    localparam logic [ADDR_W-1:0] ADDR_TX_DATA = 13'h000;  // Write TX bytes, read RX byte
    localparam logic [ADDR_W-1:0] ADDR_RX_WORD = 13'h004;  // Read only, four RX bytes
    localparam logic [ADDR_W-1:0] ADDR_CFG     = 13'h008;  // Write only
    localparam logic [ADDR_W-1:0] ADDR_CTRL    = 13'h00C;  // Write only, bit 0 kicks TX
    localparam logic [ADDR_W-1:0] ADDR_STATUS  = 13'h010;  // Reserved, always errors

    typedef struct packed {
        logic              sel;
        logic              enable;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
    } apb_req_t;

    typedef struct packed {
        logic                  valid;     // One-cycle write strobe
        logic [REG_ADDR_W-1:0] addr;
        logic [BYTE_W-1:0]     data;
        logic                  start_tx;  // Kick the UART transmitter
    } reg_wr_t;

    typedef struct packed {
        logic [BYTE_W-1:0] rx_data;  // Current received byte
        logic              tx_done;
        logic              rx_done;
    } uart_stat_t;

endpackage
